// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pid_controller
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+include
src/pid_pkg.sv
src/oversample_filter.sv
src/pid_core.sv
src/output_preprocessor.sv
src/dac_instr_queue.sv
src/dac_controller.sv
src/pid_controller.sv
verification/pid_controller_assert.sv
verification/tb_pid_controller.sv

// File: src/dac_controller.sv
`timescale 1ns/1ps

module dac_controller (
	input  logic               clk50,
	input  logic               rst_n,
	input  logic               cmd_valid,
	input  pid_pkg::chan_t     cmd_chan,
	input  pid_pkg::dac_data_t cmd_data,
	output logic               cmd_credit,
	output logic               dac_nsync,
	output logic               dac_sclk,
	output logic               dac_din
);
	import pid_pkg::*;

	chan_t                          buf_chan [DAC_CREDITS];
	dac_data_t                      buf_data [DAC_CREDITS];
	logic [$clog2(DAC_CREDITS)-1:0] wr_ptr;
	logic [$clog2(DAC_CREDITS)-1:0] rd_ptr;
	logic [W_CRED-1:0]              buf_cnt;
	dac_state_e                     state;
	logic [W_BITCNT-1:0]            cnt;	// half periods in SHIFT, cycles in GAP
	logic [W_FRAME-1:0]             frame;
	logic [W_FRAME-1:0]             shreg;
	logic                           start;

	// 4 zeros, opcode, address, code, 4 feature bits
	assign frame = {4'b0000, CMD_WRITE_UPDATE, 4'(buf_chan[rd_ptr]), buf_data[rd_ptr], 4'b0000};

	// back to back frames leave the gap straight into SHIFT
	assign start = (buf_cnt != '0) &&
		(state == IDLE || (state == GAP && cnt == W_BITCNT'(GAP_CYCLES - 1)));

	//////////////////////////////////////////////////
	// command buffer
	//////////////////////////////////////////////////

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			buf_cnt <= '0;
		end else begin
			if (cmd_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (start)
				rd_ptr <= rd_ptr + 1'b1;
			case ({cmd_valid, start})
				2'b10:   buf_cnt <= buf_cnt + 1'b1;
				2'b01:   buf_cnt <= buf_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk50) begin
		if (cmd_valid) begin
			buf_chan[wr_ptr] <= cmd_chan;
			buf_data[wr_ptr] <= cmd_data;
		end
		if (start)
			shreg <= frame << 1;	// msb leaves on the first cycle
		else if (state == SHIFT && !dac_sclk)
			shreg <= shreg << 1;
	end

	//////////////////////////////////////////////////
	// serial frame engine
	//////////////////////////////////////////////////

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			cnt        <= '0;
			cmd_credit <= 1'b0;
			dac_nsync  <= 1'b1;
			dac_sclk   <= 1'b0;
			dac_din    <= 1'b0;
		end else begin
			cmd_credit <= start;	// slot freed, hand the credit back
			if (start) begin
				state     <= SHIFT;
				cnt       <= '0;
				dac_nsync <= 1'b0;
				dac_sclk  <= 1'b1;
				dac_din   <= frame[W_FRAME-1];
			end else begin
				case (state)
					SHIFT: begin
						cnt      <= cnt + 1'b1;
						dac_sclk <= ~dac_sclk;
						if (!dac_sclk)
							dac_din <= shreg[W_FRAME-1];	// new bit with the rising sclk
						if (cnt == W_BITCNT'(2 * W_FRAME - 1)) begin
							state     <= GAP;
							cnt       <= '0;
							dac_nsync <= 1'b1;
							dac_sclk  <= 1'b0;
							dac_din   <= 1'b0;
						end
					end
					GAP: begin
						cnt <= cnt + 1'b1;
						if (cnt == W_BITCNT'(GAP_CYCLES - 1))
							state <= IDLE;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: src/dac_instr_queue.sv
`timescale 1ns/1ps

module dac_instr_queue (
	input  logic               clk50,
	input  logic               rst_n,
	input  logic               in_valid,
	input  pid_pkg::chan_t     in_chan,
	input  pid_pkg::dac_data_t in_data,
	input  logic               cmd_credit,
	output logic               cmd_valid,
	output pid_pkg::chan_t     cmd_chan,
	output pid_pkg::dac_data_t cmd_data
);
	import pid_pkg::*;

	logic [N_CHAN-1:0] pending;
	dac_data_t         code [N_CHAN];	// newest code per channel
	chan_t             oldest;		// channel that has waited longest
	logic [W_CRED-1:0] credits;		// free slots in the controller buffer
	logic [N_CHAN-1:0] pend_left;

	// oldest first, otherwise the other channel
	assign cmd_chan  = pending[oldest] ? oldest : ~oldest;
	assign cmd_valid = (credits != '0) && (pending != '0);
	assign cmd_data  = code[cmd_chan];

	always_comb begin
		pend_left = pending;
		if (cmd_valid)
			pend_left[cmd_chan] = 1'b0;
	end

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
			oldest  <= '0;
			credits <= W_CRED'(DAC_CREDITS);
		end else begin
			pending <= pend_left;
			if (in_valid)
				pending[in_chan] <= 1'b1;	// newest wins, age is kept

			// age tracking
			if (!pend_left[oldest]) begin
				if (pend_left[~oldest])
					oldest <= ~oldest;
				else if (in_valid)
					oldest <= in_chan;
			end

			case ({cmd_valid, cmd_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk50) begin
		if (in_valid)
			code[in_chan] <= in_data;
	end

endmodule

// File: src/output_preprocessor.sv
`timescale 1ns/1ps

module output_preprocessor (
	input  logic                             clk50,
	input  logic                             rst_n,
	input  logic                             in_valid,
	input  pid_pkg::chan_t                   in_chan,
	input  logic                             in_lock,
	input  pid_pkg::comp_t                   in_sum,
	input  logic signed [pid_pkg::W_MLT-1:0] multiplier,
	input  logic [pid_pkg::W_RS-1:0]         right_shift,
	input  pid_pkg::dac_data_t               out_min,
	input  pid_pkg::dac_data_t               out_max,
	input  pid_pkg::dac_data_t               out_init,
	output logic                             out_valid,
	output pid_pkg::chan_t                   out_chan,
	output pid_pkg::dac_data_t               out_data
);
	import pid_pkg::*;

	logic                           s1_valid;
	logic                           s1_lock;
	chan_t                          s1_chan;
	logic signed [W_COMP+W_MLT-1:0] s1_prod;	// sum * multiplier
	logic signed [W_COMP+W_MLT:0]   s2_val;	// scaled and offset, before the clamp

	assign s2_val = (s1_prod >>> right_shift) + $signed({1'b0, out_init});

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk50) begin
		if (in_valid) begin
			s1_chan <= in_chan;
			s1_lock <= in_lock;
			s1_prod <= in_sum * multiplier;
		end
		if (s1_valid) begin
			out_chan <= s1_chan;
			if (!s1_lock)
				out_data <= out_init;	// parked output while unlocked
			else if (s2_val > $signed({1'b0, out_max}))
				out_data <= out_max;
			else if (s2_val < $signed({1'b0, out_min}))
				out_data <= out_min;
			else
				out_data <= s2_val[W_DAC-1:0];
		end
	end

endmodule

// File: src/oversample_filter.sv
`timescale 1ns/1ps

module oversample_filter (
	input  logic               clk50,
	input  logic               rst_n,
	input  logic               in_valid,
	input  pid_pkg::chan_t     in_chan,
	input  pid_pkg::adc_data_t in_data,
	input  pid_pkg::osm_t      osm,
	output logic               out_valid,
	output pid_pkg::chan_t     out_chan,
	output pid_pkg::adc_data_t out_data
);
	import pid_pkg::*;

	logic signed [W_OSF_SUM-1:0] sum [N_CHAN];	// running sum per channel
	logic [W_OSF_CNT-1:0]        cnt [N_CHAN];	// samples taken so far
	logic signed [W_OSF_SUM-1:0] sum_nx;
	logic                        grp_last;		// this sample closes the group

	assign sum_nx   = sum[in_chan] + in_data;
	assign grp_last = (cnt[in_chan] == W_OSF_CNT'((32'd1 << osm) - 32'd1));

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < N_CHAN; c++) begin
				sum[c] <= '0;
				cnt[c] <= '0;
			end
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid && grp_last;
			if (in_valid) begin
				if (grp_last) begin
					// restart the group for this channel
					sum[in_chan] <= '0;
					cnt[in_chan] <= '0;
				end else begin
					sum[in_chan] <= sum_nx;
					cnt[in_chan] <= cnt[in_chan] + 1'b1;
				end
			end
		end
	end

	// average = sum / 2^osm
	always_ff @(posedge clk50) begin
		if (in_valid && grp_last) begin
			out_chan <= in_chan;
			out_data <= adc_data_t'(sum_nx >>> osm);
		end
	end

endmodule

// File: src/pid_controller.sv
`timescale 1ns/1ps

module pid_controller (
	input  logic                             clk50,
	input  logic                             rst_n,
	input  logic                             sample_valid,
	input  pid_pkg::chan_t                   sample_chan,
	input  pid_pkg::adc_data_t               sample_data,
	input  pid_pkg::osm_t                    osm,
	input  pid_pkg::coef_t                   setpoint,
	input  pid_pkg::coef_t                   p_coef,
	input  pid_pkg::coef_t                   i_coef,
	input  pid_pkg::coef_t                   d_coef,
	input  logic signed [pid_pkg::W_MLT-1:0] multiplier,
	input  logic [pid_pkg::W_RS-1:0]         right_shift,
	input  pid_pkg::dac_data_t               out_min,
	input  pid_pkg::dac_data_t               out_max,
	input  pid_pkg::dac_data_t               out_init,
	input  logic [pid_pkg::N_CHAN-1:0]       lock_en,
	output logic                             dac_nsync,
	output logic                             dac_sclk,
	output logic                             dac_din
);
	import pid_pkg::*;

	logic      osf_valid;	// oversample filter
	chan_t     osf_chan;
	adc_data_t osf_data;
	logic      pid_valid;	// pid core
	chan_t     pid_chan;
	logic      pid_lock;
	comp_t     pid_sum;
	logic      opp_valid;	// output preprocessor
	chan_t     opp_chan;
	dac_data_t opp_data;
	logic      cmd_valid;	// queue to controller
	chan_t     cmd_chan;
	dac_data_t cmd_data;
	logic      cmd_credit;

	oversample_filter osf0 (
		.clk50     (clk50),
		.rst_n     (rst_n),
		.in_valid  (sample_valid),
		.in_chan   (sample_chan),
		.in_data   (sample_data),
		.osm       (osm),
		.out_valid (osf_valid),
		.out_chan  (osf_chan),
		.out_data  (osf_data)
	);

	pid_core pid0 (
		.clk50     (clk50),
		.rst_n     (rst_n),
		.in_valid  (osf_valid),
		.in_chan   (osf_chan),
		.in_data   (osf_data),
		.setpoint  (setpoint),
		.p_coef    (p_coef),
		.i_coef    (i_coef),
		.d_coef    (d_coef),
		.lock_en   (lock_en),
		.out_valid (pid_valid),
		.out_chan  (pid_chan),
		.out_lock  (pid_lock),
		.out_sum   (pid_sum)
	);

	output_preprocessor opp0 (
		.clk50       (clk50),
		.rst_n       (rst_n),
		.in_valid    (pid_valid),
		.in_chan     (pid_chan),
		.in_lock     (pid_lock),
		.in_sum      (pid_sum),
		.multiplier  (multiplier),
		.right_shift (right_shift),
		.out_min     (out_min),
		.out_max     (out_max),
		.out_init    (out_init),
		.out_valid   (opp_valid),
		.out_chan    (opp_chan),
		.out_data    (opp_data)
	);

	dac_instr_queue diq0 (
		.clk50      (clk50),
		.rst_n      (rst_n),
		.in_valid   (opp_valid),
		.in_chan    (opp_chan),
		.in_data    (opp_data),
		.cmd_credit (cmd_credit),
		.cmd_valid  (cmd_valid),
		.cmd_chan   (cmd_chan),
		.cmd_data   (cmd_data)
	);

	dac_controller dac0 (
		.clk50      (clk50),
		.rst_n      (rst_n),
		.cmd_valid  (cmd_valid),
		.cmd_chan   (cmd_chan),
		.cmd_data   (cmd_data),
		.cmd_credit (cmd_credit),
		.dac_nsync  (dac_nsync),
		.dac_sclk   (dac_sclk),
		.dac_din    (dac_din)
	);

endmodule

// File: src/pid_core.sv
`timescale 1ns/1ps

module pid_core (
	input  logic                       clk50,
	input  logic                       rst_n,
	input  logic                       in_valid,
	input  pid_pkg::chan_t             in_chan,
	input  pid_pkg::adc_data_t         in_data,
	input  pid_pkg::coef_t             setpoint,
	input  pid_pkg::coef_t             p_coef,
	input  pid_pkg::coef_t             i_coef,
	input  pid_pkg::coef_t             d_coef,
	input  logic [pid_pkg::N_CHAN-1:0] lock_en,
	output logic                       out_valid,
	output pid_pkg::chan_t             out_chan,
	output logic                       out_lock,
	output pid_pkg::comp_t             out_sum
);
	import pid_pkg::*;

	logic signed [W_ADC:0]    err;		// e = setpoint - x
	logic signed [W_ADC:0]    e1 [N_CHAN];	// e[n-1]
	logic signed [W_ADC:0]    e2 [N_CHAN];	// e[n-2]
	logic signed [W_COEF+1:0] k0;
	logic signed [W_COEF+1:0] k1;
	logic                     lock_in;
	comp_t                    acc [N_CHAN];
	comp_t                    sum_nx;
	logic                     s1_valid;
	logic                     s1_lock;
	chan_t                    s1_chan;
	comp_t                    s1_delta;

	assign err     = setpoint - in_data;
	assign k0      = p_coef + i_coef + d_coef;
	assign k1      = p_coef + d_coef + d_coef;
	assign lock_in = lock_en[in_chan];

	//////////////////////////////////////////////////
	// stage 1: velocity form increment
	//////////////////////////////////////////////////

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < N_CHAN; c++) begin
				e1[c] <= '0;
				e2[c] <= '0;
			end
			s1_valid <= 1'b0;
			s1_lock  <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			if (in_valid) begin
				s1_lock <= lock_in;
				if (lock_in) begin
					e2[in_chan] <= e1[in_chan];
					e1[in_chan] <= err;
				end else begin	// unlocked, forget the history
					e2[in_chan] <= '0;
					e1[in_chan] <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (in_valid) begin
			s1_chan  <= in_chan;
			s1_delta <= k0 * err - k1 * e1[in_chan] + d_coef * e2[in_chan];
		end
	end

	//////////////////////////////////////////////////
	// stage 2: running sum
	//////////////////////////////////////////////////

	assign sum_nx = s1_lock ? acc[s1_chan] + s1_delta : '0;

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < N_CHAN; c++)
				acc[c] <= '0;
			out_valid <= 1'b0;
			out_lock  <= 1'b0;
		end else begin
			out_valid <= s1_valid;
			if (s1_valid) begin
				acc[s1_chan] <= sum_nx;
				out_lock     <= s1_lock;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (s1_valid) begin
			out_chan <= s1_chan;
			out_sum  <= sum_nx;
		end
	end

endmodule

// File: src/pid_pkg.sv
package pid_pkg;

	//////////////////////////////////////////////////
	// channels and sample path
	//////////////////////////////////////////////////

	localparam int N_CHAN = 2;			// servo channels, channel c drives dac channel c
	typedef logic [0:0] chan_t;

	localparam int W_ADC = 16;
	typedef logic signed [W_ADC-1:0] adc_data_t;

	localparam int W_OSM = 3;			// osm n averages 2^n samples
	typedef logic [W_OSM-1:0] osm_t;
	localparam int OSM_MAX = (1 << W_OSM) - 1;
	localparam int W_OSF_SUM = W_ADC + OSM_MAX;	// room for 2^OSM_MAX samples
	localparam int W_OSF_CNT = OSM_MAX;

	//////////////////////////////////////////////////
	// pid and output stage
	//////////////////////////////////////////////////

	localparam int W_COEF = 16;			// coefficients and setpoint
	typedef logic signed [W_COEF-1:0] coef_t;

	localparam int W_COMP = 40;
	typedef logic signed [W_COMP-1:0] comp_t;

	localparam int W_MLT = 16;
	localparam int W_RS = 5;

	localparam int W_DAC = 16;
	typedef logic [W_DAC-1:0] dac_data_t;

	//////////////////////////////////////////////////
	// dac8568 serial link
	//////////////////////////////////////////////////

	// control nibble of the dac frame
	typedef enum logic [3:0] {
		CMD_WRITE            = 4'd0,
		CMD_UPDATE           = 4'd1,
		CMD_WRITE_UPDATE_ALL = 4'd2,
		CMD_WRITE_UPDATE     = 4'd3
	} dac_cmd_e;

	typedef enum logic [1:0] {IDLE, SHIFT, GAP} dac_state_e;

	localparam int W_FRAME = 32;
	localparam int W_BITCNT = $clog2(2 * W_FRAME);	// counts sclk half periods
	localparam int DAC_CREDITS = 2;			// depth of the controller command buffer
	localparam int W_CRED = $clog2(DAC_CREDITS + 1);
	localparam int GAP_CYCLES = 2;			// nsync high between frames

endpackage

// File: verification/pid_controller_assert.sv
`timescale 1ns/1ps

module serial_link_checks (
	input logic                        clk50,
	input logic                        rst_n,
	input logic                        dac_nsync,
	input logic                        dac_sclk,
	input logic                        cmd_valid,
	input logic [pid_pkg::W_CRED-1:0] credits
);
	import pid_pkg::*;

	logic [7:0] low_cnt;	// cycles of the current nsync-low window

	always_ff @(posedge clk50 or negedge rst_n) begin
		if (!rst_n)
			low_cnt <= '0;
		else if (dac_nsync)
			low_cnt <= '0;
		else
			low_cnt <= low_cnt + 1'b1;
	end

	sclk_idle_low: assert property (@(posedge clk50) disable iff (!rst_n)
		dac_nsync |-> !dac_sclk)
		else $error("dac_sclk is high while dac_nsync is high");

	frame_length: assert property (@(posedge clk50) disable iff (!rst_n)
		$rose(dac_nsync) |-> low_cnt == 8'(2 * W_FRAME))
		else $error("nsync low window is not 64 cycles long");

	credit_held: assert property (@(posedge clk50) disable iff (!rst_n)
		cmd_valid |-> credits != '0)
		else $error("command issued with no credit left");

endmodule

// free buffer slots of the controller stand in for the credits
bind dac_controller serial_link_checks ctrl_chk (
	.clk50     (clk50),
	.rst_n     (rst_n),
	.dac_nsync (dac_nsync),
	.dac_sclk  (dac_sclk),
	.cmd_valid (cmd_valid),
	.credits   (pid_pkg::W_CRED'(pid_pkg::DAC_CREDITS) - buf_cnt)
);

// File: include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////
// reference model, one state set per channel
//////////////////////////////////////////////////

longint             m_osf_sum [pid_pkg::N_CHAN];
int                 m_osf_cnt [pid_pkg::N_CHAN];
longint             m_e1 [pid_pkg::N_CHAN];
longint             m_e2 [pid_pkg::N_CHAN];
pid_pkg::comp_t     m_acc [pid_pkg::N_CHAN];
pid_pkg::dac_data_t exp_codes [pid_pkg::N_CHAN][$];	// expected dac codes in order

function automatic void model_reset();
	for (int c = 0; c < pid_pkg::N_CHAN; c++) begin
		m_osf_sum[c] = 0;
		m_osf_cnt[c] = 0;
		m_e1[c]      = 0;
		m_e2[c]      = 0;
		m_acc[c]     = '0;
		exp_codes[c].delete();
	end
endfunction

// one adc sample in, an expected code out when a group completes
function automatic void model_sample(input pid_pkg::chan_t c, input pid_pkg::adc_data_t x,
	input pid_pkg::osm_t osm, input pid_pkg::coef_t sp, input pid_pkg::coef_t kp,
	input pid_pkg::coef_t ki, input pid_pkg::coef_t kd, input bit lock,
	input logic signed [pid_pkg::W_MLT-1:0] mlt, input logic [pid_pkg::W_RS-1:0] rs,
	input pid_pkg::dac_data_t omin, input pid_pkg::dac_data_t omax,
	input pid_pkg::dac_data_t oinit);
	longint avg;
	longint e;
	longint prod;
	longint val;
	m_osf_sum[c] += x;
	m_osf_cnt[c]++;
	if (m_osf_cnt[c] < (1 << osm))
		return;
	avg = pid_pkg::adc_data_t'(m_osf_sum[c] >>> osm);
	m_osf_sum[c] = 0;
	m_osf_cnt[c] = 0;
	if (!lock) begin
		m_e1[c]  = 0;
		m_e2[c]  = 0;
		m_acc[c] = '0;
		exp_codes[c].push_back(oinit);
		return;
	end
	e = longint'(sp) - avg;
	m_acc[c] = pid_pkg::comp_t'(longint'(m_acc[c]) + (longint'(kp) + ki + kd) * e
		- (longint'(kp) + kd + kd) * m_e1[c] + longint'(kd) * m_e2[c]);
	m_e2[c] = m_e1[c];
	m_e1[c] = e;
	prod = longint'(m_acc[c]) * longint'(mlt);
	val  = (prod >>> rs) + longint'(oinit);
	if (val > longint'(omax))
		exp_codes[c].push_back(omax);
	else if (val < longint'(omin))
		exp_codes[c].push_back(omin);
	else
		exp_codes[c].push_back(pid_pkg::dac_data_t'(val));
endfunction

`endif

// File: verification/tb_pid_controller.sv
`timescale 1ns/1ps

module tb_pid_controller;
	import pid_pkg::*;

	localparam int N_P      = 12;
	localparam int N_PID    = 16;
	localparam int N_OSM    = 32;
	localparam int N_CLAMP  = 8;	// per phase, three phases
	localparam int N_BURST  = 200;
	localparam int TOTAL_SAMPLES  = N_P + N_PID + N_OSM + 3 * N_CLAMP + N_BURST;
	localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * 80 + 1000;
	localparam int IDLE_RUN = 16;	// nsync high this long means the DUT has drained

	logic                 clk50;
	logic                 rst_n;
	logic                 sample_valid;
	chan_t                sample_chan;
	adc_data_t            sample_data;
	osm_t                 osm;
	coef_t                setpoint;
	coef_t                p_coef;
	coef_t                i_coef;
	coef_t                d_coef;
	logic signed [W_MLT-1:0] multiplier;
	logic [W_RS-1:0]      right_shift;
	dac_data_t            out_min;
	dac_data_t            out_max;
	dac_data_t            out_init;
	logic [N_CHAN-1:0]    lock_en;
	logic                 dac_nsync;
	logic                 dac_sclk;
	logic                 dac_din;

	integer seed = 32'h2623;
	int     cycles = 0;
	int     errors;
	int     test_errors;
	int     checks;
	int     tests_run;
	int     tests_failed;
	int     test_num;
	string  test_name;
	int     base;			// first captured frame of the current test
	chan_t  exp_chan [$];		// channel of each expected code, in order

	`include "tb_model.svh"

	always #10 clk50 = ~clk50;

	pid_controller dut0 (
		.clk50        (clk50),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.sample_chan  (sample_chan),
		.sample_data  (sample_data),
		.osm          (osm),
		.setpoint     (setpoint),
		.p_coef       (p_coef),
		.i_coef       (i_coef),
		.d_coef       (d_coef),
		.multiplier   (multiplier),
		.right_shift  (right_shift),
		.out_min      (out_min),
		.out_max      (out_max),
		.out_init     (out_init),
		.lock_en      (lock_en),
		.dac_nsync    (dac_nsync),
		.dac_sclk     (dac_sclk),
		.dac_din      (dac_din)
	);

	//////////////////////////////////////////////////
	// frame capture and run limit
	//////////////////////////////////////////////////

	logic [W_FRAME-1:0] cap_shift;
	int                 cap_bits = 0;
	logic [W_FRAME-1:0] cap_frame [$];

	// the dac samples din on the falling sclk
	always @(negedge dac_sclk or posedge dac_nsync) begin
		if (dac_nsync) begin
			cap_bits = 0;
		end else begin
			cap_shift = {cap_shift[W_FRAME-2:0], dac_din};
			cap_bits++;
			if (cap_bits == W_FRAME) begin
				cap_frame.push_back(cap_shift);
				cap_bits = 0;
			end
		end
	end

	always @(posedge clk50) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT did not finish its frames", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic note_failure(input string msg);
		$display("ERROR in test %0d: %s", test_num, msg);
		test_errors++;
	endtask

	task automatic check_code(input string name, input dac_data_t got, input dac_data_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_chan(input string name, input chan_t got, input chan_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_cmd(input string name, input dac_cmd_e got, input dac_cmd_e exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_frame_fields(input logic [W_FRAME-1:0] f);
		if (f[31:28] != 4'd0 || f[23:21] != 3'd0 || f[3:0] != 4'd0)
			note_failure($sformatf("frame %h has nonzero prefix, address or feature bits", f));
		check_cmd("frame opcode", dac_cmd_e'(f[27:24]), CMD_WRITE_UPDATE);
	endtask

	// slow tests, every code becomes a frame in model order
	task automatic check_in_order();
		int                 n;
		int                 k [N_CHAN];
		logic [W_FRAME-1:0] f;
		chan_t              c;
		n = cap_frame.size() - base;
		if (n != exp_chan.size())
			note_failure($sformatf("captured %0d frames, the model expects %0d", n, exp_chan.size()));
		for (int ch = 0; ch < N_CHAN; ch++)
			k[ch] = 0;
		for (int i = 0; i < n && i < exp_chan.size(); i++) begin
			f = cap_frame[base + i];
			c = exp_chan[i];
			check_frame_fields(f);
			check_chan("frame channel", chan_t'(f[20]), c);
			check_code("frame code", f[19:4], exp_codes[c][k[c]]);
			k[c]++;
		end
	endtask

	// burst, frames per channel are an in-order subsequence of the model list
	task automatic check_burst();
		int                 n;
		int                 k [N_CHAN];
		int                 got_n [N_CHAN];
		dac_data_t          last [N_CHAN];
		logic [W_FRAME-1:0] f;
		chan_t              c;
		n = cap_frame.size() - base;
		for (int ch = 0; ch < N_CHAN; ch++) begin
			k[ch]     = 0;
			got_n[ch] = 0;
			last[ch]  = '0;
		end
		for (int i = 0; i < n; i++) begin
			f = cap_frame[base + i];
			c = chan_t'(f[20]);
			check_frame_fields(f);
			got_n[c]++;
			last[c] = f[19:4];
			while (k[c] < exp_codes[c].size() && exp_codes[c][k[c]] != f[19:4])
				k[c]++;
			if (k[c] == exp_codes[c].size())
				note_failure($sformatf("channel %0d frame %0d code %h is out of model order",
					c, got_n[c], f[19:4]));
			else
				k[c]++;
		end
		for (int ch = 0; ch < N_CHAN; ch++) begin
			if (got_n[ch] == 0)
				note_failure($sformatf("no frame on channel %0d", ch));
			else
				check_code($sformatf("last code ch%0d", ch), last[ch], exp_codes[ch][$]);
		end
		if (n >= exp_codes[0].size() + exp_codes[1].size())
			note_failure("burst caused no back-pressure, every code became a frame");
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	function automatic int rand_span(input int span);
		return int'($unsigned($random(seed)) % span);
	endfunction

	function automatic adc_data_t rand_sample(input int amp);
		return adc_data_t'(rand_span(2 * amp + 1) - amp);
	endfunction

	function automatic chan_t rand_chan();
		return chan_t'(rand_span(2));
	endfunction

	task automatic start_test(input int num, input string name);
		test_num    = num;
		test_name   = name;
		test_errors = 0;
		@(posedge clk50);
		rst_n        <= 1'b0;
		sample_valid <= 1'b0;
	endtask

	// config only moves while rst_n is low
	task automatic configure(input osm_t o, input coef_t sp, input coef_t kp, input coef_t ki,
		input coef_t kd, input dac_data_t omin, input dac_data_t omax);
		osm         <= o;
		setpoint    <= sp;
		p_coef      <= kp;
		i_coef      <= ki;
		d_coef      <= kd;
		multiplier  <= 16'sd1;
		right_shift <= 5'd2;
		out_min     <= omin;
		out_max     <= omax;
		out_init    <= 16'h8000;
		lock_en     <= 2'b11;
	endtask

	task automatic release_reset();
		repeat (2) @(posedge clk50);
		rst_n <= 1'b1;
		model_reset();
		exp_chan.delete();
		base = cap_frame.size();
	endtask

	task automatic finish_test();
		tests_run++;
		errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d %s: %s, %0d errors", test_num, test_name,
			(test_errors == 0) ? "ok" : "failed", test_errors);
	endtask

	task automatic send_sample(input chan_t c, input adc_data_t x);
		int n_before;
		@(posedge clk50);
		sample_valid <= 1'b1;
		sample_chan  <= c;
		sample_data  <= x;
		n_before = exp_codes[c].size();
		model_sample(c, x, osm, setpoint, p_coef, i_coef, d_coef, lock_en[c], multiplier,
			right_shift, out_min, out_max, out_init);
		if (exp_codes[c].size() != n_before)
			exp_chan.push_back(c);
	endtask

	task automatic pause(input int n);
		@(posedge clk50);
		sample_valid <= 1'b0;
		repeat (n - 1) @(posedge clk50);
	endtask

	task automatic wait_idle();
		int quiet;
		quiet = 0;
		while (quiet < IDLE_RUN) begin
			@(posedge clk50);
			if (dac_nsync)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	initial begin
		clk50        = 1'b0;
		rst_n        = 1'b0;
		sample_valid = 1'b0;
		sample_chan  = '0;
		sample_data  = '0;
		osm          = '0;
		setpoint     = '0;
		p_coef       = '0;
		i_coef       = '0;
		d_coef       = '0;
		multiplier   = 16'sd1;
		right_shift  = 5'd2;
		out_min      = 16'h0000;
		out_max      = 16'hffff;
		out_init     = 16'h8000;
		lock_en      = 2'b11;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;

		start_test(1, "reset state");
		release_reset();
		@(negedge clk50);
		if (dac_nsync !== 1'b1)
			note_failure("dac_nsync is not high after reset");
		if (dac_sclk !== 1'b0)
			note_failure("dac_sclk is not low after reset");
		repeat (200) @(posedge clk50);
		if (cap_frame.size() != base)
			note_failure("a frame appeared while no samples entered");
		finish_test();

		start_test(2, "p only, osm 0");
		configure(3'd0, 16'sd0, 16'sd4, 16'sd0, 16'sd0, 16'h0000, 16'hffff);
		release_reset();
		repeat (N_P) begin
			send_sample(rand_chan(), rand_sample(2000));
			pause(90 + rand_span(21));
		end
		wait_idle();
		check_in_order();
		finish_test();

		start_test(3, "full pid, slow rate");
		configure(3'd0, 16'sd100, 16'sd3, 16'sd1, 16'sd2, 16'h0000, 16'hffff);
		release_reset();
		repeat (N_PID) begin
			send_sample(rand_chan(), rand_sample(2000));
			pause(90 + rand_span(21));
		end
		wait_idle();
		check_in_order();
		finish_test();

		start_test(4, "oversample osm 2");
		configure(3'd2, 16'sd0, 16'sd3, 16'sd1, 16'sd2, 16'h0000, 16'hffff);
		release_reset();
		repeat (N_OSM) begin
			send_sample(rand_chan(), rand_sample(2000));
			pause(30 + rand_span(20));
		end
		wait_idle();
		check_in_order();
		finish_test();

		// the integral term keeps history, so a missed restart shows after relock
		start_test(5, "clamp and unlock");
		configure(3'd0, 16'sd0, 16'sd4, 16'sd1, 16'sd0, 16'd30000, 16'd35000);
		release_reset();
		for (int i = 0; i < N_CLAMP; i++) begin	// both limits
			send_sample(rand_chan(), adc_data_t'(((i % 2) ? 12000 : -12000) + rand_span(1001) - 500));
			pause(90 + rand_span(21));
		end
		@(posedge clk50);
		lock_en <= 2'b10;	// channel 0 parked at out_init
		for (int i = 0; i < N_CLAMP; i++) begin
			send_sample(rand_chan(), rand_sample(500));
			pause(90 + rand_span(21));
		end
		@(posedge clk50);
		lock_en <= 2'b11;
		for (int i = 0; i < N_CLAMP; i++) begin
			send_sample(rand_chan(), rand_sample(500));
			pause(90 + rand_span(21));
		end
		wait_idle();
		check_in_order();
		finish_test();

		start_test(6, "burst back-pressure");
		configure(3'd0, 16'sd0, 16'sd3, 16'sd1, 16'sd2, 16'h0000, 16'hffff);
		release_reset();
		repeat (N_BURST)
			send_sample(rand_chan(), rand_sample(2000));
		pause(1);
		wait_idle();
		check_burst();
		finish_test();

		$display("%0d tests run, %0d passed, %0d failed, %0d checks, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
